// ==== logic/lwc_pkg.sv ====
package lwc_pkg;

   localparam int WORD_W = 32;
   localparam int LEN_W = 16;
   localparam logic [LEN_W-1:0] BLOCK_BYTES = LEN_W'(16);
   localparam int WORDS_PER_BLOCK = 4;

   typedef enum logic [3:0] {
      OP_ENC   = 4'd2,
      OP_LDKEY = 4'd4
   } opcode_t;

   typedef enum logic [3:0] {
      SEG_AD     = 4'd1,
      SEG_PLAIN  = 4'd4,
      SEG_CIPHER = 4'd5,
      SEG_TAG    = 4'd8,
      SEG_KEY    = 4'd12,
      SEG_NPUB   = 4'd13
   } seg_type_t;

   typedef enum logic [7:0] {
      DOM_NONE       = 8'd0,
      DOM_MSG_NORMAL = 8'd2,
      DOM_AD_NORMAL  = 8'd4,
      DOM_MSG_FINAL  = 8'd10,
      DOM_MSG_PADDED = 8'd11,
      DOM_AD_FINAL   = 8'd12,
      DOM_AD_PADDED  = 8'd13
   } domain_t;

   // zero doubles as "no output" on the pdo side
   typedef enum logic [2:0] {
      SEL_ZERO, SEL_PASS, SEL_PAD, SEL_OR_LEN,
      SEL_HDR, SEL_MASKED, SEL_FULL, SEL_TAG_HDR
   } word_sel_t;

   // slot groups must stay consecutive, the FSM steps through them by +1
   typedef enum logic [5:0] {
      S_IDLE, S_KEY_HDR, S_KEY_1, S_KEY_2, S_KEY_3, S_KEY_4,
      S_NONCE_HDR, S_NONCE_1, S_NONCE_2, S_NONCE_3, S_NONCE_4, S_ENC_NONCE,
      S_TWK_1, S_TWK_2, S_TWK_3, S_TWK_4,
      S_AD_HDR, S_AD_1, S_AD_2, S_AD_3, S_AD_4, S_ENC_AD,
      S_MSG_HDR, S_MSG_1, S_MSG_2, S_MSG_3, S_MSG_4, S_ENC_MSG,
      S_TAG_0, S_TAG_1, S_TAG_2, S_TAG_3, S_TAG_4
   } ctrl_state_t;

   localparam logic [WORD_W-1:0] TAG_HEADER = {SEG_TAG, 4'h3, 8'h00, 16'h0010};

endpackage

// ==== logic/seg_if.sv ====
`timescale 1ns/1ps

interface seg_if;
   logic                                 load;
   logic [lwc_pkg::LEN_W-1:0]            hdr_len;
   logic [3:0]                           hdr_flags;
   logic                                 block_start;
   logic                                 clear;        // end of a partial block
   logic                                 len_zero;
   logic                                 short_block;
   logic                                 last_seg;
   logic [lwc_pkg::WORDS_PER_BLOCK-1:0]  word_live;
   logic [2:0]                           tail_bytes;   // bytes in the last live word
   logic [3:0]                           len_nibble;

   modport fsm (
      output load, hdr_len, hdr_flags, block_start, clear,
      input  len_zero, short_block, last_seg, word_live
   );

   modport tracker (
      input  load, hdr_len, hdr_flags, block_start, clear,
      output len_zero, short_block, last_seg, word_live, tail_bytes, len_nibble
   );
endinterface

// ==== logic/seg_tracker.sv ====
`timescale 1ns/1ps

module seg_tracker (
   input logic    clk,
   input logic    rst,
   seg_if.tracker seg
);

   logic [lwc_pkg::LEN_W-1:0] seg_len;
   logic [lwc_pkg::LEN_W-1:0] base_len;
   logic [3:0]                flags;

   // a header load starts its first block in the same cycle
   assign base_len = seg.load ? seg.hdr_len : seg_len;

   always_ff @(posedge clk) begin
      if (rst) begin
         seg_len <= '0;
         flags   <= '0;
      end else begin
         if (seg.clear) begin
            seg_len <= '0;
         end else if (seg.block_start && !seg.short_block) begin
            seg_len <= base_len - lwc_pkg::BLOCK_BYTES;
         end else if (seg.load) begin
            seg_len <= seg.hdr_len;
         end
         if (seg.load) begin
            flags <= seg.hdr_flags;
         end
      end
   end

   assign seg.short_block = base_len < lwc_pkg::BLOCK_BYTES;
   assign seg.len_zero    = seg_len == '0;
   assign seg.last_seg    = flags[1];        // last-segment flag
   assign seg.len_nibble  = seg_len[3:0];

   always_comb begin
      for (int i = 0; i < lwc_pkg::WORDS_PER_BLOCK; i++) begin
         seg.word_live[i] = seg_len[3:0] > 4'(4 * i);
      end
   end

   assign seg.tail_bytes = (seg_len[1:0] == 2'd0) ? 3'd4 : {1'b0, seg_len[1:0]};

endmodule

// ==== logic/domain_tracker.sv ====
`timescale 1ns/1ps

module domain_tracker (
   input  logic             clk,
   input  logic             rst,
   input  lwc_pkg::domain_t domain_set,
   input  logic             dom_load,
   input  logic             cnt_set,
   input  logic             cnt_clear,
   output lwc_pkg::domain_t dom_old,
   output lwc_pkg::domain_t dom_new,
   output logic             cnt_correct
);

   lwc_pkg::domain_t dom_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         dom_q       <= lwc_pkg::DOM_NONE;
         cnt_correct <= 1'b1;
      end else begin
         if (dom_load) begin
            dom_q <= domain_set;
         end
         if (cnt_set) begin
            cnt_correct <= 1'b1;
         end else if (cnt_clear) begin
            cnt_correct <= 1'b0;      // rounds running
         end
      end
   end

   assign dom_old = dom_q;
   assign dom_new = dom_load ? domain_set : dom_q;

endmodule

// ==== logic/word_formatter.sv ====
`timescale 1ns/1ps

module word_formatter (
   input  lwc_pkg::word_sel_t          core_sel,
   input  lwc_pkg::word_sel_t          out_sel,
   input  logic [2:0]                  tail_bytes,
   input  logic [3:0]                  len_nibble,
   input  logic [lwc_pkg::WORD_W-1:0]  pdi_data,
   input  logic [lwc_pkg::WORD_W-1:0]  core_out,
   output logic [lwc_pkg::WORD_W-1:0]  core_in,
   output logic [lwc_pkg::WORD_W-1:0]  pdo_data
);

   logic [lwc_pkg::WORD_W-1:0] byte_mask;
   logic [lwc_pkg::WORD_W-1:0] pad_word;

   // keep the leading bytes, a shift of 32 leaves the full mask
   assign byte_mask = ~({lwc_pkg::WORD_W{1'b1}} >> {tail_bytes, 3'b000});
   assign pad_word  = {{(lwc_pkg::WORD_W-4){1'b0}}, len_nibble};

   always_comb begin
      case (core_sel)
         lwc_pkg::SEL_PASS:   core_in = pdi_data;
         lwc_pkg::SEL_PAD:    core_in = pad_word;
         lwc_pkg::SEL_OR_LEN: core_in = pdi_data | pad_word;
         default:             core_in = '0;
      endcase
      case (out_sel)
         lwc_pkg::SEL_HDR:     pdo_data = {lwc_pkg::SEG_CIPHER, pdi_data[27:0]};
         lwc_pkg::SEL_MASKED:  pdo_data = core_out & byte_mask;
         lwc_pkg::SEL_FULL:    pdo_data = core_out;
         lwc_pkg::SEL_TAG_HDR: pdo_data = lwc_pkg::TAG_HEADER;
         default:              pdo_data = '0;
      endcase
   end

endmodule

// ==== logic/api_fsm.sv ====
`timescale 1ns/1ps

module api_fsm #(
   parameter logic [5:0] FINAL_CONST = 6'h1A
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [lwc_pkg::WORD_W-1:0]  pdi_data,
   input  logic                        pdi_valid,
   input  logic                        sdi_valid,
   input  logic                        pdo_ready,
   input  logic [5:0]                  round_const,
   output logic                        pdi_ready,
   output logic                        sdi_ready,
   output logic                        pdo_valid,
   output logic                        state_rst,
   output logic                        state_en,
   output logic                        state_shift,
   output logic                        key_rst,
   output logic                        key_en,
   output logic                        key_shift,
   output logic                        cnt_rst,
   output logic                        tweak_load,
   output lwc_pkg::word_sel_t          core_sel,
   output lwc_pkg::word_sel_t          out_sel,
   output lwc_pkg::domain_t            domain_set,
   output logic                        dom_load,
   output logic                        cnt_set,
   output logic                        cnt_clear,
   seg_if.fsm                          seg
);

   lwc_pkg::ctrl_state_t state, nxt;
   lwc_pkg::opcode_t     opcode;
   lwc_pkg::seg_type_t   seg_type;
   logic                 blk_part, part_nxt;   // current block is partial
   logic [1:0]           slot;
   logic                 in_msg, live, last_live, step, final_rnd;

   assign opcode    = lwc_pkg::opcode_t'(pdi_data[31:28]);
   assign seg_type  = lwc_pkg::seg_type_t'(pdi_data[31:28]);
   assign final_rnd = round_const == FINAL_CONST;
   assign seg.hdr_len   = pdi_data[15:0];
   assign seg.hdr_flags = pdi_data[27:24];

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= lwc_pkg::S_IDLE;
         blk_part <= 1'b0;
      end else begin
         state    <= nxt;
         blk_part <= part_nxt;
      end
   end

   always_comb begin
      nxt = state;
      part_nxt = blk_part;
      {pdi_ready, sdi_ready, pdo_valid} = '0;
      {state_rst, state_en, state_shift, key_rst, key_en, key_shift} = '0;
      {cnt_rst, tweak_load, dom_load, cnt_set, cnt_clear} = '0;
      {seg.load, seg.block_start, seg.clear} = '0;
      core_sel = lwc_pkg::SEL_PASS;
      out_sel = lwc_pkg::SEL_ZERO;
      domain_set = lwc_pkg::DOM_NONE;
      in_msg = state inside {lwc_pkg::S_MSG_1, lwc_pkg::S_MSG_2,
                             lwc_pkg::S_MSG_3, lwc_pkg::S_MSG_4};
      slot = in_msg ? 2'(state - lwc_pkg::S_MSG_1) : 2'(state - lwc_pkg::S_AD_1);
      live = !blk_part || seg.word_live[slot];
      last_live = blk_part && live && (slot == 2'd3 || !seg.word_live[slot + 2'd1]);
      step = 1'b0;
      case (state)
         lwc_pkg::S_IDLE: begin
            dom_load = 1'b1;
            pdi_ready = !rst;        // nothing taken while in reset
            if (pdi_valid && opcode == lwc_pkg::OP_LDKEY) begin
               nxt = lwc_pkg::S_KEY_HDR;
            end else if (pdi_valid && opcode == lwc_pkg::OP_ENC) begin
               cnt_set = 1'b1;
               nxt = lwc_pkg::S_NONCE_HDR;
            end
         end
         lwc_pkg::S_KEY_HDR: begin
            pdi_ready = 1'b1;
            if (pdi_valid && seg_type == lwc_pkg::SEG_KEY) begin
               nxt = lwc_pkg::S_KEY_1;
            end
         end
         lwc_pkg::S_KEY_1, lwc_pkg::S_KEY_2, lwc_pkg::S_KEY_3, lwc_pkg::S_KEY_4: begin
            sdi_ready = 1'b1;
            if (sdi_valid) begin
               {key_rst, key_en, key_shift} = 3'b111;
               nxt = (state == lwc_pkg::S_KEY_4) ? lwc_pkg::S_IDLE
                                                 : lwc_pkg::ctrl_state_t'(state + 6'd1);
            end
         end
         lwc_pkg::S_NONCE_HDR: begin
            pdi_ready = 1'b1;
            if (pdi_valid && seg_type == lwc_pkg::SEG_NPUB) begin
               {state_rst, state_en, state_shift} = 3'b111;
               nxt = lwc_pkg::S_NONCE_1;
            end
         end
         lwc_pkg::S_NONCE_1, lwc_pkg::S_NONCE_2, lwc_pkg::S_NONCE_3,
         lwc_pkg::S_NONCE_4: begin
            pdi_ready = 1'b1;
            if (pdi_valid) begin
               {state_en, state_shift} = 2'b11;
               nxt = lwc_pkg::ctrl_state_t'(state + 6'd1);
               if (state == lwc_pkg::S_NONCE_4) begin
                  cnt_rst = 1'b1;
                  cnt_set = 1'b1;
               end
            end
         end
         lwc_pkg::S_ENC_NONCE: begin
            {state_en, key_en} = 2'b11;
            cnt_clear = !final_rnd;
            cnt_set = final_rnd;
            if (final_rnd) begin
               nxt = lwc_pkg::S_TWK_1;
            end
         end
         lwc_pkg::S_TWK_1, lwc_pkg::S_TWK_2, lwc_pkg::S_TWK_3, lwc_pkg::S_TWK_4: begin
            core_sel = lwc_pkg::SEL_ZERO;
            {state_en, state_shift, key_rst, key_en, key_shift, tweak_load} = 6'h3F;
            nxt = (state == lwc_pkg::S_TWK_4) ? lwc_pkg::S_AD_HDR
                                              : lwc_pkg::ctrl_state_t'(state + 6'd1);
         end
         lwc_pkg::S_AD_HDR: begin
            {state_rst, state_en, state_shift} = 3'b111;
            pdi_ready = 1'b1;
            if (pdi_valid && seg_type == lwc_pkg::SEG_AD) begin
               {seg.load, seg.block_start} = 2'b11;
               part_nxt = seg.short_block;
               nxt = lwc_pkg::S_AD_1;
            end
         end
         lwc_pkg::S_MSG_HDR: begin
            pdi_ready = pdo_ready;
            out_sel = lwc_pkg::SEL_HDR;
            if (seg_type inside {lwc_pkg::SEG_PLAIN, lwc_pkg::SEG_CIPHER}) begin
               pdo_valid = pdi_valid;
               if (pdi_valid && pdo_ready) begin
                  {seg.load, seg.block_start} = 2'b11;
                  part_nxt = seg.short_block;
                  nxt = lwc_pkg::S_MSG_1;
               end
            end
         end
         lwc_pkg::S_AD_1, lwc_pkg::S_AD_2, lwc_pkg::S_AD_3, lwc_pkg::S_AD_4,
         lwc_pkg::S_MSG_1, lwc_pkg::S_MSG_2, lwc_pkg::S_MSG_3, lwc_pkg::S_MSG_4: begin
            if (!live) begin
               step = 1'b1;          // empty slot, no transfer
               core_sel = (slot == 2'd3) ? lwc_pkg::SEL_PAD : lwc_pkg::SEL_ZERO;
            end else begin
               core_sel = (slot == 2'd3 && blk_part) ? lwc_pkg::SEL_OR_LEN
                                                     : lwc_pkg::SEL_PASS;
               if (in_msg) begin
                  pdi_ready = pdo_ready;
                  pdo_valid = pdi_valid;
                  out_sel = last_live ? lwc_pkg::SEL_MASKED : lwc_pkg::SEL_FULL;
                  step = pdi_valid && pdo_ready;
               end else begin
                  pdi_ready = 1'b1;
                  step = pdi_valid;
               end
            end
            if (step) begin
               {state_en, state_shift} = 2'b11;
               nxt = lwc_pkg::ctrl_state_t'(state + 6'd1);
               if (slot == 2'd3) begin
                  {key_en, key_shift, cnt_rst, cnt_set, dom_load} = 5'h1F;
                  seg.clear = blk_part;
                  if (blk_part) begin
                     domain_set = in_msg ? lwc_pkg::DOM_MSG_PADDED : lwc_pkg::DOM_AD_PADDED;
                  end else if (seg.len_zero) begin
                     domain_set = in_msg ? lwc_pkg::DOM_MSG_FINAL : lwc_pkg::DOM_AD_FINAL;
                  end else begin
                     domain_set = in_msg ? lwc_pkg::DOM_MSG_NORMAL : lwc_pkg::DOM_AD_NORMAL;
                  end
               end
            end
         end
         lwc_pkg::S_ENC_AD, lwc_pkg::S_ENC_MSG: begin
            {state_en, key_en, cnt_clear} = 3'b111;
            if (final_rnd && seg.len_zero) begin
               if (state == lwc_pkg::S_ENC_MSG) begin
                  nxt = seg.last_seg ? lwc_pkg::S_TAG_0 : lwc_pkg::S_MSG_HDR;
               end else begin
                  nxt = seg.last_seg ? lwc_pkg::S_MSG_HDR : lwc_pkg::S_AD_HDR;
               end
            end else if (final_rnd) begin
               seg.block_start = 1'b1;
               part_nxt = seg.short_block;
               nxt = (state == lwc_pkg::S_ENC_MSG) ? lwc_pkg::S_MSG_1 : lwc_pkg::S_AD_1;
            end
         end
         lwc_pkg::S_TAG_0: begin
            pdo_valid = 1'b1;
            out_sel = lwc_pkg::SEL_TAG_HDR;
            if (pdo_ready) begin
               nxt = lwc_pkg::S_TAG_1;
            end
         end
         default: begin             // tag words shifted out one per transfer
            core_sel = lwc_pkg::SEL_ZERO;
            pdo_valid = 1'b1;
            out_sel = lwc_pkg::SEL_FULL;
            if (pdo_ready) begin
               {state_en, state_shift, key_en, key_shift} = 4'hF;
               nxt = (state == lwc_pkg::S_TAG_4) ? lwc_pkg::S_IDLE
                                                 : lwc_pkg::ctrl_state_t'(state + 6'd1);
            end
         end
      endcase
   end

endmodule

// ==== logic/lwc_api_top.sv ====
`timescale 1ns/1ps

module lwc_api_top #(
   parameter logic [5:0] FINAL_CONST = 6'h1A
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic [lwc_pkg::WORD_W-1:0]            pdi_data,
   input  logic                                  pdi_valid,
   output logic                                  pdi_ready,
   input  logic                                  sdi_valid,
   output logic                                  sdi_ready,
   output logic [lwc_pkg::WORD_W-1:0]            pdo_data,
   output logic                                  pdo_valid,
   input  logic                                  pdo_ready,
   input  logic [lwc_pkg::WORD_W-1:0]            core_out,
   input  logic [5:0]                            round_const,
   output logic [lwc_pkg::WORD_W-1:0]            core_in,
   output logic                                  state_rst,
   output logic                                  state_en,
   output logic                                  state_shift,
   output logic                                  key_rst,
   output logic                                  key_en,
   output logic                                  key_shift,
   output logic                                  cnt_rst,
   output logic                                  tweak_load,
   output logic [$bits(lwc_pkg::domain_t)-1:0]   dom_old,
   output logic [$bits(lwc_pkg::domain_t)-1:0]   dom_new,
   output logic                                  cnt_correct
);

   lwc_pkg::word_sel_t core_sel, out_sel;
   lwc_pkg::domain_t   domain_set, dom_old_q, dom_new_q;
   logic               dom_load, cnt_set, cnt_clear;

   seg_if seg ();

   api_fsm #(.FINAL_CONST(FINAL_CONST)) u_fsm (
      .clk, .rst, .pdi_data, .pdi_valid, .sdi_valid, .pdo_ready, .round_const,
      .pdi_ready, .sdi_ready, .pdo_valid,
      .state_rst, .state_en, .state_shift, .key_rst, .key_en, .key_shift,
      .cnt_rst, .tweak_load, .core_sel, .out_sel, .domain_set, .dom_load,
      .cnt_set, .cnt_clear, .seg(seg.fsm)
   );

   seg_tracker u_seg (.clk, .rst, .seg(seg.tracker));

   domain_tracker u_dom (
      .clk, .rst, .domain_set, .dom_load, .cnt_set, .cnt_clear,
      .dom_old(dom_old_q), .dom_new(dom_new_q), .cnt_correct
   );

   word_formatter u_fmt (
      .core_sel, .out_sel, .tail_bytes(seg.tail_bytes), .len_nibble(seg.len_nibble),
      .pdi_data, .core_out, .core_in, .pdo_data
   );

   assign dom_old = dom_old_q;
   assign dom_new = dom_new_q;

endmodule

// ==== tests/lwc_api_checker.sv ====
`timescale 1ns/1ps

module lwc_api_checker (
   input logic                 clk,
   input logic                 rst,
   input lwc_pkg::ctrl_state_t state,
   input logic                 pdi_ready,
   input logic                 pdo_ready,
   input logic                 pdo_valid,
   input logic                 sdi_valid,
   input logic                 sdi_ready,
   input logic                 key_rst,
   input logic                 key_en,
   input logic                 key_shift,
   input logic                 cnt_rst,
   input logic                 tweak_load
);

   int fail_count = 0;

   key_on_sdi: assert property (@(posedge clk) disable iff (rst)
      sdi_valid && sdi_ready |-> key_rst && key_en && key_shift)
   else begin
      $error("key strobes missing on an sdi transfer");
      fail_count++;
   end

   // message input only moves together with the output
   msg_backpressure: assert property (@(posedge clk) disable iff (rst)
      state inside {lwc_pkg::S_MSG_HDR, lwc_pkg::S_MSG_1, lwc_pkg::S_MSG_2,
                    lwc_pkg::S_MSG_3, lwc_pkg::S_MSG_4} && pdi_ready |-> pdo_ready)
   else begin
      $error("pdi_ready high while pdo_ready low in a message state");
      fail_count++;
   end

   // a stalled tag word keeps its slot
   tag_hold: assert property (@(posedge clk) disable iff (rst)
      pdo_valid && !pdo_ready && state inside {lwc_pkg::S_TAG_0, lwc_pkg::S_TAG_1,
         lwc_pkg::S_TAG_2, lwc_pkg::S_TAG_3, lwc_pkg::S_TAG_4} |=> pdo_valid && $stable(state))
   else begin
      $error("tag word dropped before pdo_ready");
      fail_count++;
   end

   tweak_window: assert property (@(posedge clk) disable iff (rst)
      tweak_load |-> state inside {lwc_pkg::S_TWK_1, lwc_pkg::S_TWK_2,
                                   lwc_pkg::S_TWK_3, lwc_pkg::S_TWK_4})
   else begin
      $error("tweak_load outside the tweak states");
      fail_count++;
   end

   cnt_rst_slot: assert property (@(posedge clk) disable iff (rst)
      cnt_rst |-> state inside {lwc_pkg::S_NONCE_4, lwc_pkg::S_AD_4, lwc_pkg::S_MSG_4})
   else begin
      $error("cnt_rst outside a last word slot");
      fail_count++;
   end

endmodule

// ==== tests/lwc_api_tb.sv ====
`timescale 1ns/1ps

module lwc_api_tb;

   localparam logic [5:0] FINAL_CONST = 6'h1A;
   localparam int RUNS = 4;
   localparam int MAX_STALL = 16;
   localparam int MAX_WAIT = 8;

   logic        clk, rst;
   logic [31:0] pdi_data, core_out, core_in, pdo_data;
   logic        pdi_valid, pdi_ready, sdi_valid, sdi_ready, pdo_valid, pdo_ready;
   logic [5:0]  round_const;
   logic        state_rst, state_en, state_shift, key_rst, key_en, key_shift;
   logic        cnt_rst, tweak_load, cnt_correct;
   logic [7:0]  dom_old, dom_new;

   logic [15:0]      lfsr;
   logic [31:0]      pdi_q[$];
   bit               pdi_msg_q[$];
   logic [31:0]      exp_core_q[$];
   logic [31:0]      exp_pdo_val[$];  // fixed word, or byte mask on core_out
   bit               exp_pdo_core[$];
   lwc_pkg::domain_t exp_dom_q[$];
   lwc_pkg::domain_t exp_dom_old_q[$];
   lwc_pkg::domain_t model_dom;       // domain latched at the last block end
   int exp_sdi, exp_tweak, exp_cnt_rst, exp_pdi, exp_pdo;
   int n_pdi, n_pdo, n_sdi, n_key_strobe, n_tweak, n_cnt_rst, n_stall_accept;
   int n_checks, err_word, err_core, err_dom, err_count, err_other;
   int sdi_left, wait_cnt, limit_cycles;
   bit rounds_start, limit_set, cnt_rst_d;

   lwc_api_top #(.FINAL_CONST(FINAL_CONST)) u_dut (.*);

   bind api_fsm lwc_api_checker u_chk (
      .clk, .rst, .state, .pdi_ready, .pdo_ready, .pdo_valid, .sdi_valid, .sdi_ready,
      .key_rst, .key_en, .key_shift, .cnt_rst, .tweak_load
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // fibonacci taps 16 14 13 11
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [31:0] lead_mask(input int n);
      logic [31:0] m;
      m = '0;
      for (int b = 0; b < n; b++) begin
         m[31 - 8 * b -: 8] = 8'hFF;   // first byte sits in the top bits
      end
      return m;
   endfunction

   task automatic pdo_compare(input string what, input logic [lwc_pkg::WORD_W-1:0] got,
                              input logic [lwc_pkg::WORD_W-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         err_word++;
         $display("ERROR %0d ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic core_compare(input logic [lwc_pkg::WORD_W-1:0] got,
                               input logic [lwc_pkg::WORD_W-1:0] exp);
      n_checks++;
      if (got !== exp) begin
         err_core++;
         $display("ERROR %0d ns: core_in is %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic dom_compare(input string what, input lwc_pkg::domain_t got,
                              input lwc_pkg::domain_t exp);
      n_checks++;
      if (got !== exp) begin
         err_dom++;
         $display("ERROR %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic count_compare(input string what, input int got, input int exp);
      n_checks++;
      if (got != exp) begin
         err_count++;
         $display("ERROR %0d ns: %s count %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic push_pdi(input logic [31:0] w, input bit msg);
      pdi_q.push_back(w);
      pdi_msg_q.push_back(msg);
   endtask

   task automatic expect_pdo(input bit from_core, input logic [31:0] v);
      exp_pdo_core.push_back(from_core);
      exp_pdo_val.push_back(v);
   endtask

   // one AD or message segment in 16 byte blocks
   task automatic add_segment(input lwc_pkg::seg_type_t t, input bit last, input int len);
      logic [31:0]      hdr, w;
      logic [3:0]       flags;
      bit               msg;
      int               rem, n;
      lwc_pkg::domain_t d;
      msg = (t == lwc_pkg::SEG_PLAIN);
      flags = 4'(rand_bits(4));
      flags[1] = last;
      hdr = {t, flags, 8'(rand_bits(8)), 16'(len)};
      push_pdi(hdr, msg);
      if (msg) begin
         expect_pdo(1'b0, {lwc_pkg::SEG_CIPHER, hdr[27:0]});
      end
      rem = len;
      do begin
         for (int i = 0; i < 4; i++) begin
            n = (rem >= 16) ? 4 : ((rem - 4 * i > 4) ? 4 : rem - 4 * i);
            w = '0;
            if (n > 0) begin
               w = rand_bits(32) & lead_mask(n);
               push_pdi(w, msg);
               if (msg) begin
                  expect_pdo(1'b1, lead_mask(n));
               end
            end
            if (rem < 16 && i == 3) begin
               w = w | 32'(rem);        // length nibble in the last word
            end
            exp_core_q.push_back(w);
         end
         exp_cnt_rst++;
         if (rem >= 16) begin
            rem = rem - 16;
            if (rem == 0) begin
               d = msg ? lwc_pkg::DOM_MSG_FINAL : lwc_pkg::DOM_AD_FINAL;
            end else begin
               d = msg ? lwc_pkg::DOM_MSG_NORMAL : lwc_pkg::DOM_AD_NORMAL;
            end
         end else begin
            rem = 0;
            d = msg ? lwc_pkg::DOM_MSG_PADDED : lwc_pkg::DOM_AD_PADDED;
         end
         exp_dom_old_q.push_back(model_dom);
         exp_dom_q.push_back(d);
         model_dom = d;
      end while (rem > 0);
   endtask

   task automatic build_run(input bit with_key);
      logic [31:0] w;
      int          n_ad, n_msg;
      if (with_key) begin
         push_pdi({lwc_pkg::OP_LDKEY, 28'(rand_bits(28))}, 1'b0);
         push_pdi({lwc_pkg::SEG_KEY, 12'(rand_bits(12)), 16'd16}, 1'b0);
         exp_sdi += 4;
      end
      push_pdi({lwc_pkg::OP_ENC, 28'(rand_bits(28))}, 1'b0);
      push_pdi({lwc_pkg::SEG_NPUB, 12'(rand_bits(12)), 16'd16}, 1'b0);
      for (int i = 0; i < 4; i++) begin
         w = rand_bits(32);
         push_pdi(w, 1'b0);
         exp_core_q.push_back(w);
      end
      exp_dom_q.push_back(lwc_pkg::DOM_NONE);
      exp_dom_old_q.push_back(lwc_pkg::DOM_NONE);
      model_dom = lwc_pkg::DOM_NONE;
      exp_cnt_rst++;
      repeat (4) exp_core_q.push_back('0);   // tweak cycles
      exp_tweak += 4;
      n_ad = 1 + int'(rand_bits(1));
      n_msg = 1 + int'(rand_bits(1));
      for (int i = 0; i < n_ad; i++) begin
         add_segment(lwc_pkg::SEG_AD, i == n_ad - 1, int'(rand_bits(6)) % 41);
      end
      for (int i = 0; i < n_msg; i++) begin
         add_segment(lwc_pkg::SEG_PLAIN, i == n_msg - 1, int'(rand_bits(6)) % 41);
      end
      expect_pdo(1'b0, {lwc_pkg::SEG_TAG, 4'h3, 8'h00, 16'd16});
      repeat (4) begin
         expect_pdo(1'b1, '1);
         exp_core_q.push_back('0);
      end
   endtask

   task automatic drive_inputs();
      logic [1:0] pv, sv, pr;
      pv = 2'(rand_bits(2));
      sv = 2'(rand_bits(2));
      pr = 2'(rand_bits(2));
      pdi_valid = (pdi_q.size() > 0) && (pv != 2'd0);
      pdi_data = (pdi_q.size() > 0) ? pdi_q[0] : '0;
      sdi_valid = (sdi_left > 0) && (sv != 2'd0);
      pdo_ready = (pr != 2'd0);
      core_out = rand_bits(32);
      if (rounds_start) begin
         wait_cnt = int'(rand_bits(3));   // cipher rounds still to run
         rounds_start = 1'b0;
      end
      round_const = (wait_cnt > 0) ? ~FINAL_CONST : FINAL_CONST;
      if (wait_cnt > 0) begin
         wait_cnt--;
      end
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         if (cnt_rst_d) begin
            count_compare("cnt_correct after block end", int'(cnt_correct), 1);
         end
         cnt_rst_d = cnt_rst;
         if (pdi_valid && pdi_ready) begin
            n_pdi++;
            if (pdi_msg_q[0] && !(pdo_valid && pdo_ready)) begin
               n_stall_accept++;
            end
            void'(pdi_q.pop_front());
            void'(pdi_msg_q.pop_front());
         end
         if (sdi_valid && sdi_ready) begin
            n_sdi++;
            sdi_left--;
            if (key_rst && key_en && key_shift) begin
               n_key_strobe++;
            end
         end
         if (tweak_load) begin
            n_tweak++;
         end
         if (cnt_rst) begin
            n_cnt_rst++;
            rounds_start = 1'b1;
            if (exp_dom_q.size() == 0) begin
               err_other++;
               $display("cnt_rst pulse at %0d ns where no block end was due", $time);
            end else begin
               dom_compare("dom_new at block end", lwc_pkg::domain_t'(dom_new),
                           exp_dom_q.pop_front());
               dom_compare("dom_old at block end", lwc_pkg::domain_t'(dom_old),
                           exp_dom_old_q.pop_front());
            end
         end
         if (state_en && state_shift && !state_rst) begin
            if (exp_core_q.size() == 0) begin
               err_other++;
               $display("state shifted at %0d ns with no core word due", $time);
            end else begin
               core_compare(core_in, exp_core_q.pop_front());
            end
         end
         if (pdo_valid && pdo_ready) begin
            n_pdo++;
            if (exp_pdo_core.size() == 0) begin
               err_other++;
               $display("output word at %0d ns where none was due", $time);
            end else begin
               pdo_compare("pdo_data", pdo_data, exp_pdo_core[0] ?
                           (core_out & exp_pdo_val[0]) : exp_pdo_val[0]);
               void'(exp_pdo_core.pop_front());
               void'(exp_pdo_val.pop_front());
            end
         end
      end
   end

   initial begin
      wait (limit_set);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", limit_cycles);
      $display("Checks failed");
      $finish;
   end

   initial begin
      int errors;
      lfsr = 16'd23;
      rst = 1'b1;
      pdi_data = '0;
      pdi_valid = 1'b0;
      sdi_valid = 1'b0;
      pdo_ready = 1'b0;
      core_out = '0;
      round_const = '0;
      for (int r = 0; r < RUNS; r++) begin
         build_run(r == 0 || rand_bits(1) != 0);
      end
      exp_pdi = pdi_q.size();
      exp_pdo = exp_pdo_core.size();
      sdi_left = exp_sdi;
      limit_cycles = 16 + (exp_pdi + exp_pdo + exp_sdi + 4 * exp_cnt_rst)
                     * (MAX_STALL + MAX_WAIT);
      limit_set = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      dom_compare("dom_old after reset", lwc_pkg::domain_t'(dom_old), lwc_pkg::DOM_NONE);
      count_compare("cnt_correct after reset", int'(cnt_correct), 1);
      count_compare("strobe high after reset",
                    $countones({state_rst, state_en, state_shift, key_rst, key_en, key_shift,
                                cnt_rst, tweak_load, pdi_ready, sdi_ready, pdo_valid}), 0);
      rst = 1'b0;
      while (pdi_q.size() > 0 || sdi_left > 0 || exp_pdo_core.size() > 0
             || exp_core_q.size() > 0 || exp_dom_q.size() > 0) begin
         drive_inputs();
         @(negedge clk);
      end
      pdi_valid = 1'b0;
      sdi_valid = 1'b0;
      repeat (4) @(negedge clk);
      count_compare("pdi transfer", n_pdi, exp_pdi);
      count_compare("pdo transfer", n_pdo, exp_pdo);
      count_compare("sdi transfer", n_sdi, exp_sdi);
      count_compare("key strobe", n_key_strobe, exp_sdi);
      count_compare("tweak_load cycle", n_tweak, exp_tweak);
      count_compare("cnt_rst pulse", n_cnt_rst, exp_cnt_rst);
      count_compare("message word taken during stall", n_stall_accept, 0);
      count_compare("assertion failure", u_dut.u_fsm.u_chk.fail_count, 0);
      errors = err_word + err_core + err_dom + err_count + err_other;
      $display("%0d checks, errors: word %0d core %0d domain %0d count %0d other %0d",
               n_checks, err_word, err_core, err_dom, err_count, err_other);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
logic/lwc_pkg.sv
logic/seg_if.sv
logic/seg_tracker.sv
logic/domain_tracker.sv
logic/word_formatter.sv
logic/api_fsm.sv
logic/lwc_api_top.sv
tests/lwc_api_checker.sv
tests/lwc_api_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the lwc_api testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module lwc_api_tb -f sources.f -o lwc_api_sim
out=$(./obj_dir/lwc_api_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "All checks passed"
